//--- design/backend_top.sv
// integer back end top level

module backend_top import core_types_pkg::*; (
    input  logic         CLK,
    input  logic         rst,
    input  fetch_out_t   fetch_out,
    input  logic         stall_decode,
    output logic         fetch_ready,
    output exec_result_t retire
);

    uop_t         uop_in;
    uop_t         head;
    logic         queue_wen;
    logic         queue_full;
    logic         queue_empty;
    logic         pop;
    reg_idx_t     rs1_addr;
    reg_idx_t     rs2_addr;
    word_t        rs1_data;
    word_t        rs2_data;
    exec_result_t ex_out;

    // fetch holds while the queue has no room
    assign fetch_ready = !queue_full;

    decode_stage u_decode_stage (
        .CLK          (CLK),
        .rst          (rst),
        .fetch_out    (fetch_out),
        .stall_decode (stall_decode),
        .queue_full   (queue_full),
        .uop_out      (uop_in),
        .queue_wen    (queue_wen)
    );

    uop_queue u_uop_queue (
        .CLK       (CLK),
        .rst       (rst),
        .push      (queue_wen),
        .push_data (uop_in),
        .pop       (pop),
        .head      (head),
        .full      (queue_full),
        .empty     (queue_empty)
    );

    execute_stage u_execute_stage (
        .CLK      (CLK),
        .rst      (rst),
        .head     (head),
        .empty    (queue_empty),
        .pop      (pop),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .ex_out   (ex_out)
    );

    result_stage u_result_stage (
        .CLK      (CLK),
        .rst      (rst),
        .ex_in    (ex_out),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    // every execute result retires
    assign retire = ex_out;

endmodule

//--- design/core_config.svh
// core build configuration

`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// architectural integer registers, x0 included
`define CORE_NREGS 32

// micro-op queue entries
// pointers wrap naturally, so keep this a power of two
`define CORE_QUEUE_DEPTH 4

`endif

//--- design/core_types_pkg.sv
// back end shared types

package core_types_pkg;

    // basic widths
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // word coming out of fetch
    // compressed words sit in the low half of instr
    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } fetch_out_t;

    // alu operations, pass forwards the immediate for lui
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SLT,
        ALU_PASS
    } alu_op_t;

    // scalar decode result
    typedef struct packed {
        alu_op_t  alu_op;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        word_t    imm;
        logic     use_imm;
        logic     wen;
        logic     illegal_insn;
    } control_t;

    // one queue entry
    typedef struct packed {
        fetch_out_t if_out;
        control_t   ctrl_out;
    } uop_t;

    // execute output, doubles as the retire report
    typedef struct packed {
        logic     valid;
        word_t    pc;
        reg_idx_t rd;
        word_t    value;
        logic     wen;
        logic     illegal;
    } exec_result_t;

endpackage

//--- design/decode_stage.sv
// decode stage

module decode_stage import core_types_pkg::*; (
    input  logic       CLK,
    input  logic       rst,
    input  fetch_out_t fetch_out,
    input  logic       stall_decode,
    input  logic       queue_full,
    output uop_t       uop_out,
    output logic       queue_wen
);

    word_t    expanded;
    word_t    scalar_instr;
    logic     c_ena;
    control_t control;

    // compressed expansion from the low half
    rvc_expand u_rvc_expand (
        .inst16 (fetch_out.instr[15:0]),
        .inst32 (expanded),
        .c_ena  (c_ena)
    );

    // unsupported 16-bit words pass raw and decode as illegal
    assign scalar_instr = c_ena ? expanded : fetch_out.instr;

    scalar_decode u_scalar_decode (
        .instr       (scalar_instr),
        .control_out (control)
    );

    // micro-op keeps the original fetch word and pc
    always_comb begin
        uop_out.if_out   = fetch_out;
        uop_out.ctrl_out = control;
    end

    // accept only when fetch is valid, not stalled and there is room
    assign queue_wen = fetch_out.valid && !stall_decode && !queue_full;

    // a supported compressed word always expands to a legal op
    a_expanded_legal: assert property (
        @(posedge CLK) disable iff (rst) c_ena |-> !control.illegal_insn
    );

endmodule

//--- design/execute_stage.sv
// execute stage

module execute_stage import core_types_pkg::*; (
    input  logic         CLK,
    input  logic         rst,
    input  uop_t         head,
    input  logic         empty,
    output logic         pop,
    output reg_idx_t     rs1_addr,
    output reg_idx_t     rs2_addr,
    input  word_t        rs1_data,
    input  word_t        rs2_data,
    output exec_result_t ex_out
);

    control_t     ctrl;
    logic         fwd_ok;
    word_t        src1;
    word_t        src2;
    word_t        op_b;
    word_t        alu_result;
    exec_result_t ex_next;

    assign ctrl = head.ctrl_out;

    // no back-pressure downstream
    assign pop = !empty;

    assign rs1_addr = ctrl.rs1;
    assign rs2_addr = ctrl.rs2;

    // result still in flight to the register file
    assign fwd_ok = ex_out.valid && ex_out.wen && (ex_out.rd != '0);
    assign src1   = (fwd_ok && ex_out.rd == ctrl.rs1) ? ex_out.value : rs1_data;
    assign src2   = (fwd_ok && ex_out.rd == ctrl.rs2) ? ex_out.value : rs2_data;

    assign op_b = ctrl.use_imm ? ctrl.imm : src2;

    // alu
    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD:  alu_result = src1 + op_b;
            ALU_SUB:  alu_result = src1 - op_b;
            ALU_AND:  alu_result = src1 & op_b;
            ALU_OR:   alu_result = src1 | op_b;
            ALU_XOR:  alu_result = src1 ^ op_b;
            // shift amount from low five bits only
            ALU_SLL:  alu_result = src1 << op_b[4:0];
            ALU_SRL:  alu_result = src1 >> op_b[4:0];
            ALU_SLT:  alu_result = {31'b0, $signed(src1) < $signed(op_b)};
            ALU_PASS: alu_result = op_b;
            default:  alu_result = '0;
        endcase
    end

    always_comb begin
        ex_next.valid   = pop;
        ex_next.pc      = head.if_out.pc;
        ex_next.rd      = ctrl.rd;
        ex_next.value   = alu_result;
        ex_next.wen     = ctrl.wen;
        ex_next.illegal = ctrl.illegal_insn;
    end

    // registered on the popping edge
    always_ff @(posedge CLK) begin
        if (rst) begin
            ex_out <= '0;
        end else begin
            ex_out <= ex_next;
        end
    end

    // an illegal result never leaves with a write
    a_illegal_no_wen: assert property (
        @(posedge CLK) disable iff (rst)
        (ex_out.valid && ex_out.illegal) |-> !ex_out.wen
    );

endmodule

//--- design/result_stage.sv
// result stage and register file

`include "core_config.svh"

module result_stage import core_types_pkg::*; (
    input  logic         CLK,
    input  logic         rst,
    input  exec_result_t ex_in,
    input  reg_idx_t     rs1_addr,
    input  reg_idx_t     rs2_addr,
    output word_t        rs1_data,
    output word_t        rs2_data
);

    word_t regs [`CORE_NREGS];
    logic  do_write;

    // x0 is never written
    assign do_write = ex_in.valid && ex_in.wen && (ex_in.rd != '0);

    // write port, lands the edge after ex_in shows up
    always_ff @(posedge CLK) begin
        if (rst) begin
            for (int i = 0; i < `CORE_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (do_write) begin
            regs[ex_in.rd] <= ex_in.value;
        end
    end

    // combinational reads, x0 hardwired
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

//--- design/rvc_expand.sv
// compressed instruction expander

module rvc_expand (
    input  logic [15:0] inst16,
    output logic [31:0] inst32,
    output logic        c_ena
);

    // target major opcodes
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    logic [1:0]  quadrant;
    logic [2:0]  funct3;
    logic [3:0]  funct4;
    logic [4:0]  rd_rs1;
    logic [4:0]  rs2;
    logic [11:0] imm_sext;
    logic        is_compressed;

    // field split, ci and cr layouts share rd_rs1
    assign quadrant = inst16[1:0];
    assign funct3   = inst16[15:13];
    assign funct4   = inst16[15:12];
    assign rd_rs1   = inst16[11:7];
    assign rs2      = inst16[6:2];

    // ci immediate, bit 12 is the sign
    assign imm_sext = {{7{inst16[12]}}, inst16[6:2]};

    // 2'b11 marks a full-width word
    assign is_compressed = (quadrant != 2'b11);

    always_comb begin
        inst32 = '0;
        c_ena  = 1'b0;
        if (is_compressed) begin
            case (quadrant)
                2'b01: begin
                    if (funct3 == 3'b000) begin
                        // c.addi -> addi rd, rd, imm
                        inst32 = {imm_sext, rd_rs1, 3'b000, rd_rs1, OPC_OP_IMM};
                        c_ena  = 1'b1;
                    end else if (funct3 == 3'b010) begin
                        // c.li -> addi rd, x0, imm
                        inst32 = {imm_sext, 5'd0, 3'b000, rd_rs1, OPC_OP_IMM};
                        c_ena  = 1'b1;
                    end
                end
                2'b10: begin
                    // rs2 of zero is c.jr / c.jalr / c.ebreak, not supported
                    if (funct4 == 4'b1000 && rs2 != 5'd0) begin
                        // c.mv -> add rd, x0, rs2
                        inst32 = {7'b0000000, rs2, 5'd0, 3'b000, rd_rs1, OPC_OP};
                        c_ena  = 1'b1;
                    end else if (funct4 == 4'b1001 && rs2 != 5'd0) begin
                        // c.add -> add rd, rd, rs2
                        inst32 = {7'b0000000, rs2, rd_rs1, 3'b000, rd_rs1, OPC_OP};
                        c_ena  = 1'b1;
                    end
                end
                default: begin
                    // quadrant 0 unsupported, left to scalar decode as illegal
                    c_ena = 1'b0;
                end
            endcase
        end
    end

endmodule

//--- design/scalar_decode.sv
// scalar integer decoder

module scalar_decode import core_types_pkg::*; (
    input  word_t    instr,
    output control_t control_out
);

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       legal;
    alu_op_t    op_sel;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // operation select and legality
    always_comb begin
        legal  = 1'b0;
        op_sel = ALU_ADD;
        case (opcode)
            OPC_OP: begin
                legal = (funct7 == F7_BASE);
                case (funct3)
                    3'b000: begin
                        // add / sub split on funct7
                        op_sel = (funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
                        legal  = (funct7 == F7_BASE) || (funct7 == F7_ALT);
                    end
                    3'b001:  op_sel = ALU_SLL;
                    3'b010:  op_sel = ALU_SLT;
                    3'b100:  op_sel = ALU_XOR;
                    3'b101:  op_sel = ALU_SRL;
                    3'b110:  op_sel = ALU_OR;
                    3'b111:  op_sel = ALU_AND;
                    // sltu not supported
                    default: legal  = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                legal = 1'b1;
                case (funct3)
                    3'b000:  op_sel = ALU_ADD;
                    3'b010:  op_sel = ALU_SLT;
                    3'b100:  op_sel = ALU_XOR;
                    3'b110:  op_sel = ALU_OR;
                    3'b111:  op_sel = ALU_AND;
                    // shift immediates need a clean upper field, srai is out
                    3'b001: begin
                        op_sel = ALU_SLL;
                        legal  = (funct7 == F7_BASE);
                    end
                    3'b101: begin
                        op_sel = ALU_SRL;
                        legal  = (funct7 == F7_BASE);
                    end
                    default: legal  = 1'b0;
                endcase
            end
            OPC_LUI: begin
                legal  = 1'b1;
                op_sel = ALU_PASS;
            end
            default: legal = 1'b0;
        endcase
    end

    // control struct
    always_comb begin
        control_out.alu_op       = legal ? op_sel : ALU_ADD;
        control_out.rs1          = instr[19:15];
        control_out.rs2          = instr[24:20];
        control_out.rd           = instr[11:7];
        control_out.use_imm      = (opcode != OPC_OP);
        // u-type fills upper bits, i-type sign extends bit 31
        if (opcode == OPC_LUI) begin
            control_out.imm = {instr[31:12], 12'b0};
        end else begin
            control_out.imm = {{20{instr[31]}}, instr[31:20]};
        end
        // illegal words never write
        control_out.wen          = legal;
        control_out.illegal_insn = !legal;
    end

endmodule

//--- design/uop_queue.sv
// micro-op fifo

`include "core_config.svh"

module uop_queue import core_types_pkg::*; #(
    parameter int DEPTH = `CORE_QUEUE_DEPTH
) (
    input  logic CLK,
    input  logic rst,
    input  logic push,
    input  uop_t push_data,
    input  logic pop,
    output uop_t head,
    output logic full,
    output logic empty
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam logic [PTR_W:0] FULL_COUNT = (PTR_W + 1)'(DEPTH);

    uop_t             mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;

    // pointers wrap on their own width
    always_ff @(posedge CLK) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // occupancy, simultaneous push and pop cancel
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage
    always_ff @(posedge CLK) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // head visible the cycle after the push
    assign head  = mem[rd_ptr];
    assign full  = (count == FULL_COUNT);
    assign empty = (count == '0);

    a_no_push_full: assert property (
        @(posedge CLK) disable iff (rst) !(push && full)
    );
    a_no_pop_empty: assert property (
        @(posedge CLK) disable iff (rst) !(pop && empty)
    );

endmodule

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module backend_tb -o backend_sim

./obj_dir/backend_sim | tee sim.log

if grep -q "^Test completed successfully$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

//--- sim.f
+incdir+design
+incdir+test
design/core_types_pkg.sv
design/rvc_expand.sv
design/scalar_decode.sv
design/decode_stage.sv
design/uop_queue.sv
design/execute_stage.sv
design/result_stage.sv
design/backend_top.sv
test/backend_tb.sv

//--- test/backend_model.svh
// back end reference model

`ifndef BACKEND_MODEL_SVH
`define BACKEND_MODEL_SVH

// architectural state as the program sees it
logic [31:0] model_regs [`CORE_NREGS];

// x0 reads zero whatever is stored
function automatic logic [31:0] model_read(input logic [4:0] idx);
    return (idx == 5'd0) ? 32'd0 : model_regs[idx];
endfunction

// integer functions picked by funct3, sub only on the add slot
function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic sub,
                                        input logic [31:0] a, input logic [31:0] b);
    case (f3)
        3'b000:  return sub ? a - b : a + b;
        3'b001:  return a << b[4:0];
        3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b100:  return a ^ b;
        3'b101:  return a >> b[4:0];
        3'b110:  return a | b;
        default: return a & b;
    endcase
endfunction

// one fetch word through the model, returns the expected retire
function automatic exec_result_t model_exec(input logic [31:0] pc, input logic [31:0] instr);
    exec_result_t res;
    logic [4:0]   rd;
    logic [2:0]   f3;
    logic [6:0]   f7;
    logic [31:0]  a;
    logic [31:0]  b;
    logic [31:0]  cimm;
    logic [31:0]  v;
    logic         ok;
    rd   = instr[11:7];
    f3   = instr[14:12];
    f7   = instr[31:25];
    a    = model_read(instr[19:15]);
    b    = model_read(instr[24:20]);
    // six bit ci immediate, sign in bit 12
    cimm = {{26{instr[12]}}, instr[12], instr[6:2]};
    v    = 32'd0;
    ok   = 1'b1;
    if (instr[1:0] == 2'b01 && instr[15:13] == 3'b000) begin
        // c.addi
        v = model_read(rd) + cimm;
    end else if (instr[1:0] == 2'b01 && instr[15:13] == 3'b010) begin
        // c.li
        v = cimm;
    end else if (instr[1:0] == 2'b10 && instr[15:12] == 4'b1000 && instr[6:2] != 5'd0) begin
        // c.mv
        v = model_read(instr[6:2]);
    end else if (instr[1:0] == 2'b10 && instr[15:12] == 4'b1001 && instr[6:2] != 5'd0) begin
        // c.add
        v = model_read(rd) + model_read(instr[6:2]);
    end else if (instr[6:0] == 7'b0110111) begin
        // lui
        v = {instr[31:12], 12'd0};
    end else if (instr[6:0] == 7'b0010011) begin
        // op-imm, no sltiu, shifts need a zero upper field
        ok = (f3 != 3'b011) && !((f3 == 3'b001 || f3 == 3'b101) && f7 != 7'd0);
        v  = alu_ref(f3, 1'b0, a, {{20{instr[31]}}, instr[31:20]});
    end else if (instr[6:0] == 7'b0110011) begin
        // op, alternate funct7 only for sub
        ok = (f3 != 3'b011) && (f7 == 7'd0 || (f7 == 7'b0100000 && f3 == 3'b000));
        v  = alu_ref(f3, f7[5], a, b);
    end else begin
        ok = 1'b0;
    end
    res.valid   = 1'b1;
    res.pc      = pc;
    res.rd      = rd;
    res.value   = v;
    res.wen     = ok;
    res.illegal = !ok;
    if (ok && rd != 5'd0) begin
        model_regs[rd] = v;
    end
    return res;
endfunction

`endif

//--- test/backend_tb.sv
// back end testbench

`include "core_config.svh"

module backend_tb import core_types_pkg::*; ();

    localparam int NUM_INSTR   = 2000;
    localparam int RUN_LIMIT   = 20000;
    localparam int DRAIN_LIMIT = 200;

    logic         CLK;
    logic         rst;
    fetch_out_t   fetch_out;
    logic         stall_decode;
    logic         fetch_ready;
    exec_result_t retire;

    integer       seed;
    int           value_errors;
    int           order_errors;
    int           timeouts;
    int           accepted;
    int           retired;
    int           cycles;
    logic [31:0]  next_pc;
    exec_result_t exp_q [$];

    `include "backend_model.svh"

    backend_top dut_i (
        .CLK          (CLK),
        .rst          (rst),
        .fetch_out    (fetch_out),
        .stall_decode (stall_decode),
        .fetch_ready  (fetch_ready),
        .retire       (retire)
    );

    always #5 CLK = ~CLK;

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    // x0..x7 only, so dependencies and x0 writes come often
    function automatic logic [4:0] rand_reg();
        logic [31:0] r;
        r = rand_word();
        return {2'b00, r[2:0]};
    endfunction

    // one word from the instruction templates
    function automatic logic [31:0] make_instr();
        logic [31:0] r;
        logic [31:0] w;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rs2c;
        logic [11:0] imm12;
        r     = rand_word();
        w     = rand_word();
        rd    = rand_reg();
        rs1   = rand_reg();
        rs2   = rand_reg();
        // compressed mv / add need a nonzero rs2
        rs2c  = (rs2 == 5'd0) ? 5'd1 : rs2;
        // shift immediates keep the upper field clear
        imm12 = (w[13:12] == 2'b01) ? {7'd0, w[24:20]} : w[31:20];
        case (r[7:0] % 10)
            0, 1: return {(w[14:12] == 3'b000 && w[31]) ? 7'b0100000 : 7'b0000000,
                          rs2, rs1, w[14:12], rd, 7'b0110011};
            2, 3: return {imm12, rs1, w[14:12], rd, 7'b0010011};
            4:    return {w[31:12], rd, 7'b0110111};
            5:    return {w[31:16], 3'b010, w[5], rd, w[4:0], 2'b01};
            6:    return {w[31:16], 3'b000, w[5], rd, w[4:0], 2'b01};
            7:    return {w[31:16], 4'b1000, rd, rs2c, 2'b10};
            8:    return {w[31:16], 4'b1001, rd, rs2c, 2'b10};
            // quadrant 0 or custom-0 opcode, both illegal
            default: return r[11] ? {w[31:2], 2'b00} : {w[31:7], 7'b0001011};
        endcase
    endfunction

    task automatic load_word();
        fetch_out.valid = 1'b1;
        fetch_out.pc    = next_pc;
        fetch_out.instr = make_instr();
        // compressed words step the pc by two
        next_pc = next_pc + ((fetch_out.instr[1:0] == 2'b11) ? 32'd4 : 32'd2);
    endtask

    task automatic check_field(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        assert (exp_v == act_v) else begin
            value_errors++;
            $display("FAILED %s expected %h actual %h", name, exp_v, act_v);
        end
    endtask

    // front of the expected queue against the retire port
    task automatic check_retire();
        exec_result_t exp;
        if (retire.valid) begin
            retired++;
            assert (exp_q.size() != 0) else begin
                order_errors++;
                $display("retire at pc %h has no accepted word to match", retire.pc);
            end
            if (exp_q.size() != 0) begin
                exp = exp_q.pop_front();
                check_field("retire.pc", exp.pc, retire.pc);
                check_field("retire.illegal", 32'(exp.illegal), 32'(retire.illegal));
                check_field("retire.wen", 32'(exp.wen), 32'(retire.wen));
                // illegal words carry no meaningful rd or value
                if (!exp.illegal) begin
                    check_field("retire.rd", 32'(exp.rd), 32'(retire.rd));
                    check_field("retire.value", exp.value, retire.value);
                end
            end
        end
    endtask

    // sample mid-cycle, then drive just after the edge
    task automatic step_cycle();
        logic [31:0] r;
        logic        took;
        @(negedge CLK);
        check_retire();
        took = fetch_out.valid && !stall_decode && fetch_ready;
        if (took) begin
            exp_q.push_back(model_exec(fetch_out.pc, fetch_out.instr));
            accepted++;
        end
        @(posedge CLK);
        #1;
        r = rand_word();
        // stall about a quarter of the cycles
        stall_decode = (r[1:0] == 2'b00);
        if (took) begin
            if (accepted < NUM_INSTR) begin
                load_word();
            end else begin
                fetch_out.valid = 1'b0;
            end
        end
    endtask

    initial begin
        CLK          = 1'b0;
        rst          = 1'b1;
        seed         = 30;
        fetch_out    = '0;
        stall_decode = 1'b0;
        value_errors = 0;
        order_errors = 0;
        timeouts     = 0;
        accepted     = 0;
        retired      = 0;
        next_pc      = 32'h0000_1000;
        for (int i = 0; i < `CORE_NREGS; i++) begin
            model_regs[i] = 32'd0;
        end
        repeat (4) @(posedge CLK);
        #1;
        rst = 1'b0;
        assert (fetch_ready) else begin
            order_errors++;
            $display("fetch_ready is low right after reset");
        end
        load_word();

        // main run, bounded in cycles
        cycles = 0;
        while (accepted < NUM_INSTR && cycles < RUN_LIMIT) begin
            step_cycle();
            cycles++;
        end
        if (accepted < NUM_INSTR) begin
            timeouts++;
            $display("run timed out after %0d cycles, %0d words accepted", cycles, accepted);
        end
        fetch_out.valid = 1'b0;

        // drain whatever is still in flight
        cycles = 0;
        while (exp_q.size() != 0 && cycles < DRAIN_LIMIT) begin
            step_cycle();
            cycles++;
        end
        if (exp_q.size() != 0) begin
            timeouts++;
            $display("drain timed out with %0d retires outstanding", exp_q.size());
        end
        // idle cycles catch any extra retire
        for (int i = 0; i < 4; i++) begin
            step_cycle();
        end
        assert (retired == accepted) else begin
            order_errors++;
            $display("%0d words accepted but %0d retired", accepted, retired);
        end

        // final register file, x0 included
        for (int i = 0; i < `CORE_NREGS; i++) begin
            check_field($sformatf("regs[%0d]", i), model_regs[i], dut_i.u_result_stage.regs[i]);
        end

        $display("errors: value %0d, order %0d, timeout %0d", value_errors, order_errors,
                 timeouts);
        if (value_errors == 0 && order_errors == 0 && timeouts == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
